/* rv_core.f */
source/rv_pkg.sv
source/rv_alu.sv
source/rv_fetch.sv
source/rv_regfile.sv
source/rv_decode.sv
source/rv_execute.sv
source/rv_result.sv
source/rv_core_top.sv
test/tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - source/rv_pkg.sv
  - source/rv_alu.sv
  - source/rv_fetch.sv
  - source/rv_regfile.sv
  - source/rv_decode.sv
  - source/rv_execute.sv
  - source/rv_result.sv
  - source/rv_core_top.sv
  - target: test
    files:
      - test/tb_rv_core.sv

/* test/tb_rv_core.sv */
// ================================================
// Random forward-only programs ending in a JAL to self
// Checks run as assertions against a reference model
// ================================================
`timescale 1ns/1ps

module tb_rv_core
  import rv_pkg::*;
();

  localparam int NUM_RETIRE     = 300;
  localparam int TIMEOUT_CYCLES = NUM_RETIRE * 8;

  logic      clk;
  logic      rst_n;
  logic      wb_cyc, wb_stb, wb_we, wb_ack;
  word_t     wb_adr, wb_dat_i;
  logic      retire_valid, retire_wen;
  word_t     retire_pc, retire_insn, retire_data;
  reg_addr_t retire_rd;

  word_t     mem [256];
  word_t     shadow [32];
  word_t     seed;
  word_t     exp_pc, exp_next, exp_data, exp_insn;
  reg_addr_t exp_rd;
  logic      exp_wen;
  int        retire_count;
  int        cycle_count;
  int        wait_left;

  rv_core_top u_dut (
    .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_ack, .wb_dat_i,
    .retire_valid, .retire_pc, .retire_insn, .retire_rd, .retire_wen, .retire_data
  );

  function automatic word_t lcg_step(input word_t s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic next_rand(output word_t r);
    seed = lcg_step(seed);
    r    = seed;
  endtask

  function automatic word_t enc_branch(input logic [12:0] off, input reg_addr_t rs2, rs1,
                                       input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic word_t enc_jal(input logic [20:0] off, input reg_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  task automatic generate_program();
    word_t      r;
    word_t      s;
    word_t      op_imm_word;
    logic [6:0] f7_imm;
    logic [6:0] f7_op;
    int         fwd;
    for (int i = 0; i < 256; i++) mem[i] = NOP_INSN;
    for (int i = 0; i < 255; i++) begin
      next_rand(r);
      next_rand(s);
      fwd = (i + 1 + s[1:0] > 255) ? 255 - i : 1 + s[1:0]; // 1 to 4 words ahead
      f7_imm = r[31:25];
      if (r[14:12] == F3_SLL) f7_imm = F7_BASE;
      if (r[14:12] == F3_SR) f7_imm = r[30] ? F7_ALT : F7_BASE;
      f7_op = ((r[14:12] == F3_ADD || r[14:12] == F3_SR) && r[30]) ? F7_ALT : F7_BASE;
      op_imm_word = {f7_imm, r[24:7], OPC_OP_IMM};
      case (s[31:29])
        3'd0:    mem[i] = {r[31:12], r[11:7], OPC_LUI};
        3'd1:    mem[i] = {r[31:12], r[11:7], OPC_AUIPC};
        3'd2:    mem[i] = enc_branch(13'(fwd * 4), r[24:20], r[19:15], r[14:12]);
        3'd3:    mem[i] = s[28] ? enc_jal(21'(fwd * 4), r[11:7]) : op_imm_word;
        3'd6:    mem[i] = {f7_op, r[24:7], OPC_OP};
        3'd7:    mem[i] = s[28] ? NOP_INSN : {r[31:7], 7'b0000011}; // Loads are unsupported
        default: mem[i] = op_imm_word;
      endcase
    end
    mem[255] = enc_jal(21'd0, 5'd0);
  endtask

  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt, input word_t a, b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input word_t a, b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      3'b111:  return a >= b;
      default: return 1'b0; // Reserved funct3 retires as a no-op
    endcase
  endfunction

  // Expected outcome of the instruction on the retire port
  always_comb begin
    logic [2:0] f3;
    logic [6:0] f7;
    word_t      a;
    word_t      b;
    word_t      imm_i;
    f3       = retire_insn[14:12];
    f7       = retire_insn[31:25];
    a        = shadow[retire_insn[19:15]];
    b        = shadow[retire_insn[24:20]];
    imm_i    = {{20{retire_insn[31]}}, retire_insn[31:20]};
    exp_rd   = retire_insn[11:7];
    exp_wen  = 1'b0;
    exp_data = '0;
    exp_next = exp_pc + 32'd4;
    case (retire_insn[6:0])
      OPC_LUI: begin
        exp_wen  = 1'b1;
        exp_data = {retire_insn[31:12], 12'b0};
      end
      OPC_AUIPC: begin
        exp_wen  = 1'b1;
        exp_data = exp_pc + {retire_insn[31:12], 12'b0};
      end
      OPC_JAL: begin
        exp_wen  = 1'b1;
        exp_data = exp_pc + 32'd4;
        exp_next = exp_pc + {{12{retire_insn[31]}}, retire_insn[19:12], retire_insn[20],
                             retire_insn[30:21], 1'b0};
      end
      OPC_BRANCH: begin
        if (branch_taken(f3, a, b))
          exp_next = exp_pc + {{20{retire_insn[31]}}, retire_insn[7], retire_insn[30:25],
                               retire_insn[11:8], 1'b0};
      end
      OPC_OP_IMM: begin
        exp_wen  = (f3 != 3'd1 || f7 == 7'h00) && (f3 != 3'd5 || f7 == 7'h00 || f7 == 7'h20);
        exp_data = alu_ref(f3, f3 == 3'd5 && f7[5], a, imm_i);
      end
      OPC_OP: begin
        exp_wen  = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        exp_data = alu_ref(f3, f7[5], a, b);
      end
      default: ;
    endcase
    if (exp_rd == '0) exp_wen = 1'b0;
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) shadow[i] <= '0;
      exp_pc       <= RESET_PC;
      retire_count <= 0;
    end else if (retire_valid) begin
      if (exp_wen) shadow[exp_rd] <= exp_data;
      exp_pc       <= exp_next;
      retire_count <= retire_count + 1;
    end
  end

  assign exp_insn = mem[exp_pc[9:2]]; // Program word at the expected pc

  // Wishbone slave with 0 to 3 wait states per read
  always @(negedge clk) begin
    word_t r;
    if (!rst_n) begin
      wb_ack    = 1'b0;
      wait_left = 0;
    end else if (wb_ack) begin
      wb_ack = 1'b0;
    end else if (wb_stb) begin
      if (wait_left == 0) begin
        wb_ack   = 1'b1;
        wb_dat_i = mem[wb_adr[9:2]];
        next_rand(r);
        wait_left = int'(r[31:30]);
      end else begin
        wait_left--;
      end
    end
  end

  task automatic report_failure(input string msg);
    $display("Fail at time %0t: %s", $time, msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  a_reset_state: assert property (@(posedge clk) $rose(rst_n) |->
    !wb_cyc && !retire_valid ##1 wb_cyc && wb_adr == RESET_PC)
    else report_failure("bus or retire port active after reset, or first fetch not at 0");

  a_read_only: assert property (@(posedge clk) !wb_we)
    else report_failure("wb_we asserted on the instruction port");

  a_adr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr))
    else report_failure("wb_adr or wb_stb changed while waiting for ack");

  a_ack_latency: assert property (@(posedge clk) disable iff (!rst_n)
    wb_stb && wb_ack |-> !retire_valid [*3] ##1 retire_valid)
    else report_failure("retire_valid not exactly 3 cycles after ack");

  a_retire_pc: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid |-> retire_pc == exp_pc)
    else report_failure($sformatf("retire_pc %h, expected %h",
                                  $sampled(retire_pc), $sampled(exp_pc)));

  a_retire_insn: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid |-> retire_insn == exp_insn)
    else report_failure($sformatf("retire_insn %h at pc %h, expected %h",
                                  $sampled(retire_insn), $sampled(exp_pc), $sampled(exp_insn)));

  a_retire_wen: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid |-> retire_wen == exp_wen)
    else report_failure($sformatf("retire_wen %b for insn %h, expected %b",
                                  $sampled(retire_wen), $sampled(retire_insn), $sampled(exp_wen)));

  a_retire_data: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid && exp_wen |-> retire_rd == exp_rd && retire_data == exp_data)
    else report_failure($sformatf("insn %h wrote x%0d = %h, expected x%0d = %h",
                                  $sampled(retire_insn), $sampled(retire_rd),
                                  $sampled(retire_data), $sampled(exp_rd), $sampled(exp_data)));

  // exp_pc has already moved on to the next address by the checked cycle
  a_next_fetch: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid |=> wb_cyc && wb_adr == exp_pc)
    else report_failure($sformatf("next fetch at %h, expected %h",
                                  $sampled(wb_adr), $sampled(exp_pc)));

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with only %0d instructions retired",
               cycle_count, retire_count);
      $display("*** TEST FAILED ***");
      $fatal(1, "run did not finish in time");
    end
  end

  initial begin
    rst_n       = 1'b0;
    wb_ack      = 1'b0;
    wb_dat_i    = '0;
    seed        = 32'hc169_77bd;
    cycle_count = 0;
    generate_program();
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    wait (retire_count == NUM_RETIRE);
    @(negedge clk);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* source/rv_core_top.sv */
// ================================================
// RV32I subset core, one instruction in flight
// Read-only Wishbone classic port for fetch
// ================================================
`timescale 1ns/1ps

module rv_core_top
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  output logic      wb_cyc,
  output logic      wb_stb,
  output logic      wb_we,
  output word_t     wb_adr,
  input  logic      wb_ack,
  input  word_t     wb_dat_i,
  output logic      retire_valid,
  output word_t     retire_pc,
  output word_t     retire_insn,
  output reg_addr_t retire_rd,
  output logic      retire_wen,
  output word_t     retire_data
);

  logic      insn_valid, dec_valid, ex_valid, redirect_valid;
  logic      use_imm, use_pc, is_jal, rd_wen, ex_wen, wr_en;
  word_t     insn, insn_pc, rs1_data, rs2_data, imm, op_a, op_b, dec_pc, dec_insn;
  word_t     ex_res, redirect_pc, ex_pc, ex_insn, wr_data;
  reg_addr_t rs1_addr, rs2_addr, rd, ex_rd, wr_addr;
  alu_op_e   alu_op;
  br_type_e  br_type;

  rv_fetch u_fetch (
    .clk, .rst_n, .wb_ack, .wb_dat_i, .redirect_valid, .redirect_pc, .retire_valid,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .insn_valid, .insn, .insn_pc
  );

  rv_regfile u_regfile (
    .clk, .rst_n, .rs1_addr, .rs2_addr, .wr_addr, .wr_en, .wr_data, .rs1_data, .rs2_data
  );

  rv_decode u_decode (
    .clk, .rst_n, .insn_valid, .insn, .insn_pc, .rs1_data, .rs2_data,
    .rs1_addr, .rs2_addr, .dec_valid, .alu_op, .br_type, .imm, .use_imm, .use_pc,
    .is_jal, .rd, .rd_wen, .op_a, .op_b, .pc (dec_pc), .dec_insn
  );

  rv_execute u_execute (
    .clk, .rst_n, .dec_valid, .alu_op, .br_type, .imm, .use_imm, .use_pc, .is_jal,
    .rd, .rd_wen, .op_a, .op_b, .pc (dec_pc), .insn (dec_insn),
    .ex_valid, .ex_res, .ex_rd, .ex_wen, .redirect_valid, .redirect_pc, .ex_pc, .ex_insn
  );

  rv_result u_result (
    .clk, .rst_n, .ex_valid, .ex_res, .ex_rd, .ex_wen, .ex_pc, .ex_insn,
    .wr_en, .wr_addr, .wr_data, .retire_valid, .retire_pc, .retire_insn,
    .retire_rd, .retire_wen, .retire_data
  );

endmodule

/* source/rv_result.sv */
// ================================================
// Write-back and retire report on the same edge
// ================================================
`timescale 1ns/1ps

module rv_result
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      ex_valid,
  input  word_t     ex_res,
  input  reg_addr_t ex_rd,
  input  logic      ex_wen,
  input  word_t     ex_pc,
  input  word_t     ex_insn,
  output logic      wr_en,
  output reg_addr_t wr_addr,
  output word_t     wr_data,
  output logic      retire_valid,
  output word_t     retire_pc,
  output word_t     retire_insn,
  output reg_addr_t retire_rd,
  output logic      retire_wen,
  output word_t     retire_data
);

  // The register file commits on the edge that raises retire_valid
  assign wr_en   = ex_valid && ex_wen;
  assign wr_addr = ex_rd;
  assign wr_data = ex_res;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      retire_valid <= 1'b0;
      retire_wen   <= 1'b0;
    end else begin
      retire_valid <= ex_valid;
      retire_wen   <= ex_valid && ex_wen;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid) begin
      retire_pc   <= ex_pc;
      retire_insn <= ex_insn;
      retire_rd   <= ex_rd;
      retire_data <= ex_res;
    end
  end

  // Decode drops writes to x0 two stages earlier
  a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
    retire_wen |-> retire_rd != '0);

endmodule

/* source/rv_execute.sv */
// ================================================
// Execute stage, resolves branches and JAL here
// No prediction, every taken transfer redirects
// ================================================
`timescale 1ns/1ps

module rv_execute
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      dec_valid,
  input  alu_op_e   alu_op,
  input  br_type_e  br_type,
  input  word_t     imm,
  input  logic      use_imm,
  input  logic      use_pc,
  input  logic      is_jal,
  input  reg_addr_t rd,
  input  logic      rd_wen,
  input  word_t     op_a,
  input  word_t     op_b,
  input  word_t     pc,
  input  word_t     insn,
  output logic      ex_valid,
  output word_t     ex_res,
  output reg_addr_t ex_rd,
  output logic      ex_wen,
  output logic      redirect_valid,
  output word_t     redirect_pc,
  output word_t     ex_pc,
  output word_t     ex_insn
);

  word_t alu_a, alu_b, alu_res;
  logic  br_taken;

  assign alu_a = use_pc ? pc : op_a; // AUIPC adds to the pc
  assign alu_b = use_imm ? imm : op_b;

  rv_alu u_alu (
    .a      (alu_a),
    .b      (alu_b),
    .alu_op (alu_op),
    .res    (alu_res)
  );

  always_comb begin
    case (br_type)
      BR_BEQ:  br_taken = (op_a == op_b);
      BR_BNE:  br_taken = (op_a != op_b);
      BR_BLT:  br_taken = ($signed(op_a) < $signed(op_b));
      BR_BGE:  br_taken = ($signed(op_a) >= $signed(op_b));
      BR_BLTU: br_taken = (op_a < op_b);
      BR_BGEU: br_taken = (op_a >= op_b);
      default: br_taken = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid       <= 1'b0;
      ex_wen         <= 1'b0;
      redirect_valid <= 1'b0;
    end else begin
      ex_valid       <= dec_valid;
      ex_wen         <= dec_valid && rd_wen;
      redirect_valid <= dec_valid && (is_jal || br_taken);
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      ex_res      <= is_jal ? pc + 32'd4 : alu_res; // JAL links the return address
      ex_rd       <= rd;
      redirect_pc <= pc + imm;
      ex_pc       <= pc;
      ex_insn     <= insn;
    end
  end

  a_redirect_valid: assert property (@(posedge clk) disable iff (!rst_n)
    redirect_valid |-> ex_valid);

endmodule

/* source/rv_decode.sv */
// ================================================
// Registered decode, one instruction per insn_valid
// Illegal encodings come out as writes disabled
// ================================================
`timescale 1ns/1ps

module rv_decode
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      insn_valid,
  input  word_t     insn,
  input  word_t     insn_pc,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  output reg_addr_t rs1_addr,
  output reg_addr_t rs2_addr,
  output logic      dec_valid,
  output alu_op_e   alu_op,
  output br_type_e  br_type,
  output word_t     imm,
  output logic      use_imm,
  output logic      use_pc,
  output logic      is_jal,
  output reg_addr_t rd,
  output logic      rd_wen,
  output word_t     op_a,
  output word_t     op_b,
  output word_t     pc,
  output word_t     dec_insn
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rd_idx;
  word_t      imm_i, imm_u, imm_b, imm_j;
  alu_op_e    alu_op_d;
  br_type_e   br_type_d;
  word_t      imm_d;
  logic       use_imm_d, use_pc_d, is_jal_d, wen_d;

  assign opcode   = insn[6:0];
  assign funct3   = insn[14:12];
  assign funct7   = insn[31:25];
  assign rd_idx   = insn[11:7];
  assign rs1_addr = insn[19:15];
  assign rs2_addr = insn[24:20];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

  always_comb begin
    alu_op_d  = ALU_ADD;
    br_type_d = BR_NONE;
    imm_d     = imm_i;
    use_imm_d = 1'b0;
    use_pc_d  = 1'b0;
    is_jal_d  = 1'b0;
    wen_d     = 1'b0;
    case (opcode)
      OPC_LUI: begin
        alu_op_d  = ALU_PASS_B;
        imm_d     = imm_u;
        use_imm_d = 1'b1;
        wen_d     = 1'b1;
      end
      OPC_AUIPC: begin
        imm_d     = imm_u;
        use_imm_d = 1'b1;
        use_pc_d  = 1'b1;
        wen_d     = 1'b1;
      end
      OPC_JAL: begin
        imm_d    = imm_j;
        is_jal_d = 1'b1;
        wen_d    = 1'b1;
      end
      OPC_BRANCH: begin
        imm_d = imm_b;
        case (funct3)
          F3_BEQ:  br_type_d = BR_BEQ;
          F3_BNE:  br_type_d = BR_BNE;
          F3_BLT:  br_type_d = BR_BLT;
          F3_BGE:  br_type_d = BR_BGE;
          F3_BLTU: br_type_d = BR_BLTU;
          F3_BGEU: br_type_d = BR_BGEU;
          default: br_type_d = BR_NONE; // funct3 010 and 011 are illegal
        endcase
      end
      OPC_OP_IMM, OPC_OP: begin
        use_imm_d = (opcode == OPC_OP_IMM);
        wen_d     = 1'b1;
        case (funct3)
          F3_ADD:  alu_op_d = (!use_imm_d && funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
          F3_SLL:  alu_op_d = ALU_SLL;
          F3_SLT:  alu_op_d = ALU_SLT;
          F3_SLTU: alu_op_d = ALU_SLTU;
          F3_XOR:  alu_op_d = ALU_XOR;
          F3_SR:   alu_op_d = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
          F3_OR:   alu_op_d = ALU_OR;
          default: alu_op_d = ALU_AND;
        endcase
        // Only the shifts check funct7 for OP-IMM, every OP does
        if (funct3 == F3_SLL && funct7 != F7_BASE) wen_d = 1'b0;
        if (funct3 == F3_SR && funct7 != F7_BASE && funct7 != F7_ALT) wen_d = 1'b0;
        if (!use_imm_d && funct7 != F7_BASE &&
            !(funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR))) wen_d = 1'b0;
      end
      default: ;
    endcase
    if (rd_idx == '0) wen_d = 1'b0;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
      rd_wen    <= 1'b0;
    end else begin
      dec_valid <= insn_valid;
      rd_wen    <= insn_valid && wen_d;
    end
  end

  always_ff @(posedge clk) begin
    if (insn_valid) begin
      alu_op   <= alu_op_d;
      br_type  <= br_type_d;
      imm      <= imm_d;
      use_imm  <= use_imm_d;
      use_pc   <= use_pc_d;
      is_jal   <= is_jal_d;
      rd       <= rd_idx;
      op_a     <= rs1_data;
      op_b     <= rs2_data;
      pc       <= insn_pc;
      dec_insn <= insn;
    end
  end

endmodule

/* source/rv_regfile.sv */
// ================================================
// 32 x 32 register file, x0 reads as zero
// ================================================
`timescale 1ns/1ps

module rv_regfile
  import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  input  reg_addr_t wr_addr,
  input  logic      wr_en,
  input  word_t     wr_data,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  word_t regs [32];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data; // x0 stays zero since it is never written
    end
  end

  // Reads are combinational, the write lands on the following edge
  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

endmodule

/* source/rv_fetch.sv */
// ================================================
// Wishbone classic read master, one read in flight
// Next read waits for retire of the current insn
// ================================================
`timescale 1ns/1ps

module rv_fetch
  import rv_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  wb_ack,
  input  word_t wb_dat_i,
  input  logic  redirect_valid,
  input  word_t redirect_pc,
  input  logic  retire_valid,
  output logic  wb_cyc,
  output logic  wb_stb,
  output logic  wb_we,
  output word_t wb_adr,
  output logic  insn_valid,
  output word_t insn,
  output word_t insn_pc
);

  fetch_state_e state;
  word_t        pc_q;
  logic         redir_pending;
  word_t        redir_target;

  assign wb_cyc = (state == FETCH_BUS);
  assign wb_stb = wb_cyc;
  assign wb_we  = 1'b0; // Instruction port never writes
  assign wb_adr = pc_q;

  // Decode samples the read data on the ack edge itself
  assign insn_valid = wb_cyc && wb_ack;
  assign insn       = wb_dat_i;
  assign insn_pc    = pc_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= FETCH_IDLE;
      pc_q          <= RESET_PC;
      redir_pending <= 1'b0;
    end else begin
      if (redirect_valid) redir_pending <= 1'b1;
      case (state)
        FETCH_IDLE: state <= FETCH_BUS;
        FETCH_BUS:  if (wb_ack) state <= FETCH_WAIT;
        FETCH_WAIT: begin
          if (retire_valid) begin
            state         <= FETCH_BUS;
            pc_q          <= redir_pending ? redir_target : pc_q + 32'd4;
            redir_pending <= 1'b0;
          end
        end
        default: state <= FETCH_IDLE;
      endcase
    end
  end

  // The target arrives one cycle ahead of retire and is held until then
  always_ff @(posedge clk) begin
    if (redirect_valid) redir_target <= redirect_pc;
  end

  a_wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr));

endmodule

/* source/rv_alu.sv */
// ================================================
// Combinational RV32I ALU, shifts use b[4:0] only
// ================================================
`timescale 1ns/1ps

module rv_alu
  import rv_pkg::*;
(
  input  word_t   a,
  input  word_t   b,
  input  alu_op_e alu_op,
  output word_t   res
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (alu_op)
      ALU_ADD:    res = a + b;
      ALU_SUB:    res = a - b;
      ALU_SLL:    res = a << shamt;
      ALU_SLT:    res = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU:   res = {31'b0, a < b};
      ALU_XOR:    res = a ^ b;
      ALU_SRL:    res = a >> shamt;
      ALU_SRA:    res = word_t'($signed(a) >>> shamt);
      ALU_OR:     res = a | b;
      ALU_AND:    res = a & b;
      ALU_PASS_B: res = b; // LUI gets its value straight from the immediate
      default:    res = '0;
    endcase
  end

endmodule

/* source/rv_pkg.sv */
// ================================================
// Shared types and encodings for the RV32I core
// Only the subset without loads, stores and JALR
// ================================================
package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // Major opcodes, low two bits included
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101; // SRL or SRA, told apart by funct7
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB and SRA

  localparam word_t RESET_PC = 32'h0000_0000;
  localparam word_t NOP_INSN = 32'h0000_0013; // ADDI x0, x0, 0

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
  } br_type_e;

  typedef enum logic [1:0] {FETCH_IDLE, FETCH_BUS, FETCH_WAIT} fetch_state_e;

endpackage
